//--- mmu_macros.svh
// Memory unit widths and register map
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Address split
`define MMU_VADDR_W     20
`define MMU_PAGE_OFS_W  6
`define MMU_VTAG_W      (`MMU_VADDR_W - `MMU_PAGE_OFS_W)
`define MMU_PTAG_W      6
`define MMU_DID_W       2

`define MMU_DWORD_W     32

// TLB and RAM sizing
`define MMU_TLB_ELS     4
`define MMU_RAM_WORDS   256

`define MMU_APB_ADDR_W    8
`define MMU_REG_CTRL      8'h00
`define MMU_REG_TLB_VTAG  8'h04
`define MMU_REG_TLB_ENTRY 8'h08
`define MMU_REG_TLB_WRITE 8'h0C
`define MMU_REG_TLB_FLUSH 8'h10

`endif

//--- mmu_pkg.sv
// Memory unit shared types
`include "mmu_macros.svh"

package mmu_pkg;

  typedef logic [`MMU_VADDR_W-1:0]    vaddr_t;
  typedef logic [`MMU_VTAG_W-1:0]     vtag_t;
  typedef logic [`MMU_PTAG_W-1:0]     ptag_t;
  typedef logic [`MMU_PAGE_OFS_W-1:0] page_ofs_t;
  typedef logic [`MMU_DWORD_W-1:0]    dword_t;

  typedef logic [$clog2(`MMU_RAM_WORDS)-1:0] ram_addr_t;
  typedef logic [$clog2(`MMU_TLB_ELS)-1:0]   tlb_idx_t;

  // u, w, d from bit 2 down
  typedef logic [2:0] pte_flags_t;

  typedef enum logic [1:0] {
    e_priv_u = 2'd0,
    e_priv_s = 2'd1,
    e_priv_m = 2'd3
  } priv_mode_e;

  typedef enum logic {
    e_op_load  = 1'b0,
    e_op_store = 1'b1
  } mem_op_e;

  // Listed in decreasing priority after none
  typedef enum logic [2:0] {
    e_exc_none               = 3'd0,
    e_exc_tlb_miss           = 3'd1,
    e_exc_load_page_fault    = 3'd2,
    e_exc_store_page_fault   = 3'd3,
    e_exc_load_access_fault  = 3'd4,
    e_exc_store_access_fault = 3'd5
  } exc_code_e;

endpackage

//--- mmu_cfg_regs.sv
// APB configuration registers
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_cfg_regs (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [`MMU_APB_ADDR_W-1:0] paddr_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  mmu_pkg::dword_t            pwdata_i,
  output mmu_pkg::dword_t            prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  output logic                       translation_en_o,
  output mmu_pkg::priv_mode_e        priv_mode_o,
  output logic                       sum_o,
  output logic                       tlb_w_v_o,
  output mmu_pkg::tlb_idx_t          tlb_w_idx_o,
  output mmu_pkg::vtag_t             tlb_w_vtag_o,
  output mmu_pkg::ptag_t             tlb_w_ptag_o,
  output mmu_pkg::pte_flags_t        tlb_w_flags_o,
  output logic                       tlb_flush_o
);
  import mmu_pkg::*;

  logic       access;
  logic       wr_en;
  logic       sel_ctrl;
  logic       sel_vtag;
  logic       sel_entry;
  logic       sel_write;
  logic       sel_flush;
  logic       en_r;
  priv_mode_e priv_r;
  logic       sum_r;
  vtag_t      stage_vtag_r;
  ptag_t      stage_ptag_r;
  pte_flags_t stage_flags_r;

  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  assign sel_ctrl  = (paddr_i == `MMU_REG_CTRL);
  assign sel_vtag  = (paddr_i == `MMU_REG_TLB_VTAG);
  assign sel_entry = (paddr_i == `MMU_REG_TLB_ENTRY);
  assign sel_write = (paddr_i == `MMU_REG_TLB_WRITE);
  assign sel_flush = (paddr_i == `MMU_REG_TLB_FLUSH);

  // Zero wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~(sel_ctrl | sel_vtag | sel_entry | sel_write | sel_flush);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_r   <= 1'b0;
      priv_r <= e_priv_u;
      sum_r  <= 1'b0;
    end else if (wr_en && sel_ctrl) begin
      en_r   <= pwdata_i[0];
      priv_r <= priv_mode_e'(pwdata_i[2:1]);
      sum_r  <= pwdata_i[3];
    end
  end

  // Staged TLB entry
  always_ff @(posedge clk_i) begin
    if (wr_en && sel_vtag) begin
      stage_vtag_r <= pwdata_i[`MMU_VTAG_W-1:0];
    end
    if (wr_en && sel_entry) begin
      stage_ptag_r  <= pwdata_i[`MMU_PTAG_W-1:0];
      stage_flags_r <= pwdata_i[`MMU_PTAG_W +: $bits(pte_flags_t)];
    end
  end

  always_comb begin
    prdata_o = '0;
    if (sel_ctrl) begin
      prdata_o[3:0] = {sum_r, priv_r, en_r};
    end else if (sel_vtag) begin
      prdata_o[`MMU_VTAG_W-1:0] = stage_vtag_r;
    end else if (sel_entry) begin
      prdata_o[`MMU_PTAG_W+2:0] = {stage_flags_r, stage_ptag_r};
    end
  end

  // Strobes land in the TLB on the edge ending the access phase
  assign tlb_w_v_o     = wr_en & sel_write;
  assign tlb_w_idx_o   = pwdata_i[$bits(tlb_idx_t)-1:0];
  assign tlb_w_vtag_o  = stage_vtag_r;
  assign tlb_w_ptag_o  = stage_ptag_r;
  assign tlb_w_flags_o = stage_flags_r;
  assign tlb_flush_o   = wr_en & sel_flush;

  assign translation_en_o = en_r;
  assign priv_mode_o      = priv_r;
  assign sum_o            = sum_r;

endmodule

//--- dtlb.sv
// Fully associative data TLB
`timescale 1ns/1ps
`include "mmu_macros.svh"

module dtlb (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                flush_i,
  input  logic                w_v_i,
  input  mmu_pkg::tlb_idx_t   w_idx_i,
  input  mmu_pkg::vtag_t      w_vtag_i,
  input  mmu_pkg::ptag_t      w_ptag_i,
  input  mmu_pkg::pte_flags_t w_flags_i,
  input  mmu_pkg::vtag_t      r_vtag_i,
  output logic                hit_o,
  output mmu_pkg::ptag_t      ptag_o,
  output mmu_pkg::pte_flags_t flags_o
);
  import mmu_pkg::*;

  logic [`MMU_TLB_ELS-1:0] valid_r;
  vtag_t                   vtag_r  [`MMU_TLB_ELS];
  ptag_t                   ptag_r  [`MMU_TLB_ELS];
  pte_flags_t              flags_r [`MMU_TLB_ELS];
  logic [`MMU_TLB_ELS-1:0] match;

  // Flush wins over a same-cycle write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else if (flush_i) begin
      valid_r <= '0;
    end else if (w_v_i) begin
      valid_r[w_idx_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_v_i && !flush_i) begin
      vtag_r[w_idx_i]  <= w_vtag_i;
      ptag_r[w_idx_i]  <= w_ptag_i;
      flags_r[w_idx_i] <= w_flags_i;
    end
  end

  // Parallel tag compare
  always_comb begin
    for (int i = 0; i < `MMU_TLB_ELS; i++) begin
      match[i] = valid_r[i] & (vtag_r[i] == r_vtag_i);
    end
  end

  // Lowest matching slot wins if a tag was installed twice
  always_comb begin
    hit_o   = |match;
    ptag_o  = '0;
    flags_o = '0;
    for (int i = `MMU_TLB_ELS - 1; i >= 0; i--) begin
      if (match[i]) begin
        ptag_o  = ptag_r[i];
        flags_o = flags_r[i];
      end
    end
  end

endmodule

//--- mmu_perm_check.sv
// Page and access fault check
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_perm_check (
  input  logic                translation_en_i,
  input  mmu_pkg::priv_mode_e priv_mode_i,
  input  logic                sum_i,
  input  mmu_pkg::mem_op_e    op_i,
  input  logic                hit_i,
  input  mmu_pkg::ptag_t      ptag_i,
  input  mmu_pkg::pte_flags_t flags_i,
  output mmu_pkg::exc_code_e  exc_o
);
  import mmu_pkg::*;

  logic pte_u;
  logic pte_w;
  logic pte_d;
  logic is_store;
  logic priv_fault;
  logic write_fault;
  logic did_fault;

  assign {pte_u, pte_w, pte_d} = flags_i;
  assign is_store = (op_i == e_op_store);

  // Supervisor needs SUM for user pages, user needs u
  assign priv_fault = ((priv_mode_i == e_priv_s) & ~sum_i & pte_u)
                    | ((priv_mode_i == e_priv_u) & ~pte_u);
  assign write_fault = is_store & (~pte_w | ~pte_d);

  // Only domain zero is local
  assign did_fault = (ptag_i[`MMU_PTAG_W-1 -: `MMU_DID_W] != '0);

  always_comb begin
    if (translation_en_i && !hit_i) begin
      exc_o = e_exc_tlb_miss;
    end else if (translation_en_i && (priv_fault || write_fault)) begin
      exc_o = is_store ? e_exc_store_page_fault : e_exc_load_page_fault;
    end else if (did_fault) begin
      exc_o = is_store ? e_exc_store_access_fault : e_exc_load_access_fault;
    end else begin
      exc_o = e_exc_none;
    end
  end

endmodule

//--- data_ram.sv
// Word-wide data RAM
`timescale 1ns/1ps
`include "mmu_macros.svh"

module data_ram (
  input  logic               clk_i,
  input  mmu_pkg::ram_addr_t addr_i,
  input  logic               we_i,
  input  mmu_pkg::dword_t    wdata_i,
  output mmu_pkg::dword_t    rdata_o
);
  import mmu_pkg::*;

  dword_t mem [`MMU_RAM_WORDS];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // Read returns old contents on a write cycle
  always_ff @(posedge clk_i) begin
    rdata_o <= mem[addr_i];
  end

endmodule

//--- mem_top.sv
// Data memory unit top
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mem_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [`MMU_APB_ADDR_W-1:0] paddr_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  mmu_pkg::dword_t            pwdata_i,
  output mmu_pkg::dword_t            prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  input  logic                       cmd_v_i,
  input  mmu_pkg::mem_op_e           cmd_op_i,
  input  mmu_pkg::vaddr_t            cmd_vaddr_i,
  input  mmu_pkg::dword_t            cmd_data_i,
  output logic                       cmd_ready_o,
  output logic                       resp_v_o,
  output mmu_pkg::dword_t            resp_data_o,
  output mmu_pkg::exc_code_e         resp_exc_o,
  input  logic                       resp_ready_i
);
  import mmu_pkg::*;

  logic       translation_en;
  priv_mode_e priv_mode;
  logic       sum;
  logic       tlb_w_v;
  tlb_idx_t   tlb_w_idx;
  vtag_t      tlb_w_vtag;
  ptag_t      tlb_w_ptag;
  pte_flags_t tlb_w_flags;
  logic       tlb_flush;

  logic       s1_v_r;
  mem_op_e    s1_op_r;
  vaddr_t     s1_vaddr_r;
  dword_t     s1_data_r;
  vtag_t      s1_vtag;
  page_ofs_t  s1_ofs;
  logic       tlb_hit;
  ptag_t      tlb_ptag;
  pte_flags_t tlb_flags;
  ptag_t      s1_ptag;
  exc_code_e  s1_exc;
  ram_addr_t  s1_ram_addr;

  logic       s2_v_r;
  exc_code_e  s2_exc_r;
  logic       s2_load_r;
  ram_addr_t  s2_ram_addr_r;

  logic       stall;
  ram_addr_t  ram_addr;
  logic       ram_we;
  dword_t     ram_rdata;

  mmu_cfg_regs cfg0 (
    .clk_i(clk_i), .reset_i(reset_i),
    .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
    .pwrite_i(pwrite_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
    .pready_o(pready_o), .pslverr_o(pslverr_o),
    .translation_en_o(translation_en), .priv_mode_o(priv_mode), .sum_o(sum),
    .tlb_w_v_o(tlb_w_v), .tlb_w_idx_o(tlb_w_idx), .tlb_w_vtag_o(tlb_w_vtag),
    .tlb_w_ptag_o(tlb_w_ptag), .tlb_w_flags_o(tlb_w_flags), .tlb_flush_o(tlb_flush)
  );

  // Whole pipe holds while a response waits
  assign stall       = s2_v_r & ~resp_ready_i;
  assign cmd_ready_o = ~stall;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
      s2_v_r <= 1'b0;
    end else if (!stall) begin
      s1_v_r <= cmd_v_i;
      s2_v_r <= s1_v_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall && cmd_v_i) begin
      s1_op_r    <= cmd_op_i;
      s1_vaddr_r <= cmd_vaddr_i;
      s1_data_r  <= cmd_data_i;
    end
  end

  assign s1_vtag = s1_vaddr_r[`MMU_VADDR_W-1 -: `MMU_VTAG_W];
  assign s1_ofs  = s1_vaddr_r[`MMU_PAGE_OFS_W-1:0];

  dtlb dtlb0 (
    .clk_i(clk_i), .reset_i(reset_i), .flush_i(tlb_flush),
    .w_v_i(tlb_w_v), .w_idx_i(tlb_w_idx), .w_vtag_i(tlb_w_vtag),
    .w_ptag_i(tlb_w_ptag), .w_flags_i(tlb_w_flags),
    .r_vtag_i(s1_vtag), .hit_o(tlb_hit), .ptag_o(tlb_ptag), .flags_o(tlb_flags)
  );

  // Bypass takes the low tag bits as physical
  assign s1_ptag = translation_en ? tlb_ptag : s1_vtag[`MMU_PTAG_W-1:0];

  mmu_perm_check chk0 (
    .translation_en_i(translation_en), .priv_mode_i(priv_mode), .sum_i(sum),
    .op_i(s1_op_r), .hit_i(tlb_hit), .ptag_i(s1_ptag), .flags_i(tlb_flags),
    .exc_o(s1_exc)
  );

  assign s1_ram_addr = {s1_ptag[`MMU_PTAG_W-`MMU_DID_W-1:0], s1_ofs[`MMU_PAGE_OFS_W-1:2]};

  // Replay the stage 2 address while stalled so read data holds
  assign ram_addr = stall ? s2_ram_addr_r : s1_ram_addr;
  assign ram_we   = s1_v_r & ~stall & (s1_op_r == e_op_store) & (s1_exc == e_exc_none);

  data_ram ram0 (
    .clk_i(clk_i), .addr_i(ram_addr), .we_i(ram_we),
    .wdata_i(s1_data_r), .rdata_o(ram_rdata)
  );

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      s2_exc_r      <= s1_exc;
      s2_load_r     <= (s1_op_r == e_op_load) & (s1_exc == e_exc_none);
      s2_ram_addr_r <= s1_ram_addr;
    end
  end

  assign resp_v_o    = s2_v_r;
  assign resp_exc_o  = s2_exc_r;
  assign resp_data_o = s2_load_r ? ram_rdata : '0;

endmodule

//--- tb_clkgen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic reset_o
);
  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

//--- tb_mem_top.sv
// Memory unit testbench
`timescale 1ns/1ps
`include "mmu_macros.svh"

module tb_mem_top;
  import mmu_pkg::*;

  // About five times the expected run length
  localparam int MAX_CYCLES = 4000;

  logic                       clk;
  logic                       reset;
  logic [`MMU_APB_ADDR_W-1:0] paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  dword_t                     pwdata;
  dword_t                     prdata;
  logic                       pready;
  logic                       pslverr;
  logic                       cmd_v;
  mem_op_e                    cmd_op;
  vaddr_t                     cmd_vaddr;
  dword_t                     cmd_data;
  logic                       cmd_ready;
  logic                       resp_v;
  dword_t                     resp_data;
  exc_code_e                  resp_exc;
  logic                       resp_ready;

  // Reference state
  logic       m_en;
  priv_mode_e m_priv;
  logic       m_sum;
  logic       m_valid [`MMU_TLB_ELS];
  vtag_t      m_vtag  [`MMU_TLB_ELS];
  ptag_t      m_ptag  [`MMU_TLB_ELS];
  pte_flags_t m_flags [`MMU_TLB_ELS];
  dword_t     ram_model [`MMU_RAM_WORDS];

  exc_code_e   exp_exc_q [$];
  dword_t      exp_data_q [$];
  int          acc_cycle_q [$];
  int          cycle_cnt;
  int          errors;
  int          checks;
  logic        ready_random;

  tb_clkgen clkgen0 (.clk_o(clk), .reset_o(reset));

  mem_top dut0 (
    .clk_i(clk), .reset_i(reset),
    .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .cmd_v_i(cmd_v), .cmd_op_i(cmd_op), .cmd_vaddr_i(cmd_vaddr), .cmd_data_i(cmd_data),
    .cmd_ready_o(cmd_ready), .resp_v_o(resp_v), .resp_data_o(resp_data),
    .resp_exc_o(resp_exc), .resp_ready_i(resp_ready)
  );

  function automatic vaddr_t make_vaddr(input vtag_t vtag, input logic [3:0] word);
    return {vtag, word, 2'b00};
  endfunction

  // Expected exception, data and RAM index from the translation rules
  function automatic void predict_response(input mem_op_e op, input vaddr_t va,
                                           output exc_code_e exc, output dword_t rd,
                                           output ram_addr_t idx);
    vtag_t      vtag;
    ptag_t      ptag;
    pte_flags_t fl;
    logic       hit;
    logic       st;
    logic       pg_fault;
    vtag = va[`MMU_VADDR_W-1:`MMU_PAGE_OFS_W];
    st   = (op == e_op_store);
    hit  = 1'b0;
    fl   = '0;
    ptag = vtag[`MMU_PTAG_W-1:0];
    for (int i = `MMU_TLB_ELS - 1; i >= 0; i--) begin
      if (m_en && m_valid[i] && m_vtag[i] == vtag) begin
        hit  = 1'b1;
        ptag = m_ptag[i];
        fl   = m_flags[i];
      end
    end
    pg_fault = (m_priv == e_priv_s && !m_sum && fl[2]) || (m_priv == e_priv_u && !fl[2])
             || (st && !(fl[1] && fl[0]));
    if (m_en && !hit) begin
      exc = e_exc_tlb_miss;
    end else if (m_en && pg_fault) begin
      exc = st ? e_exc_store_page_fault : e_exc_load_page_fault;
    end else if (ptag[5:4] != 2'b00) begin
      exc = st ? e_exc_store_access_fault : e_exc_load_access_fault;
    end else begin
      exc = e_exc_none;
    end
    idx = {ptag[3:0], va[5:2]};
    rd  = (!st && exc == e_exc_none) ? ram_model[idx] : '0;
  endfunction

  task automatic check_value(input string name, input dword_t got, input dword_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %s expected=%h got=%h", name, exp, got);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [`MMU_APB_ADDR_W-1:0] addr,
                          input dword_t wdata, output dword_t rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    do @(posedge clk); while (!pready);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_ctrl(input logic en, input priv_mode_e priv, input logic sum);
    dword_t rd;
    logic   err;
    apb_xfer(1'b1, `MMU_REG_CTRL, dword_t'({sum, priv, en}), rd, err);
    m_en   = en;
    m_priv = priv;
    m_sum  = sum;
  endtask

  task automatic install_entry(input tlb_idx_t slot, input vtag_t vtag, input ptag_t ptag,
                               input pte_flags_t fl);
    dword_t rd;
    logic   err;
    apb_xfer(1'b1, `MMU_REG_TLB_VTAG, dword_t'(vtag), rd, err);
    apb_xfer(1'b1, `MMU_REG_TLB_ENTRY, dword_t'({fl, ptag}), rd, err);
    apb_xfer(1'b1, `MMU_REG_TLB_WRITE, dword_t'(slot), rd, err);
    m_valid[slot] = 1'b1;
    m_vtag[slot]  = vtag;
    m_ptag[slot]  = ptag;
    m_flags[slot] = fl;
  endtask

  task automatic flush_tlb();
    dword_t rd;
    logic   err;
    apb_xfer(1'b1, `MMU_REG_TLB_FLUSH, 32'h1, rd, err);
    for (int i = 0; i < `MMU_TLB_ELS; i++) begin
      m_valid[i] = 1'b0;
    end
  endtask

  // Holds the command until accepted, then records the prediction
  task automatic issue_cmd(input mem_op_e op, input vaddr_t va, input dword_t data);
    exc_code_e exc;
    dword_t    rd;
    ram_addr_t idx;
    @(negedge clk);
    cmd_v     = 1'b1;
    cmd_op    = op;
    cmd_vaddr = va;
    cmd_data  = data;
    do @(posedge clk); while (!cmd_ready);
    predict_response(op, va, exc, rd, idx);
    if (op == e_op_store && exc == e_exc_none) begin
      ram_model[idx] = data;
    end
    exp_exc_q.push_back(exc);
    exp_data_q.push_back(rd);
    acc_cycle_q.push_back(cycle_cnt);
  endtask

  task automatic wait_drain();
    @(negedge clk);
    cmd_v = 1'b0;
    while (exp_exc_q.size() != 0) @(posedge clk);
    @(negedge clk);
  endtask

  always @(posedge clk) begin : monitor_resp
    int acc;
    if (!reset && resp_v && resp_ready) begin
      assert (exp_exc_q.size() != 0) else begin
        errors++;
        $display("A response arrived with no command outstanding");
      end
      if (exp_exc_q.size() != 0) begin
        check_value("resp_exc_o", dword_t'(resp_exc), dword_t'(exp_exc_q.pop_front()));
        check_value("resp_data_o", resp_data, exp_data_q.pop_front());
        acc = acc_cycle_q.pop_front();
        if (!ready_random) begin
          assert (cycle_cnt - acc == 2) else begin
            errors++;
            $display("Response came %0d cycles after acceptance instead of 2",
                     cycle_cnt - acc);
          end
        end
      end
    end
  end

  always @(negedge clk) begin
    resp_ready <= ready_random ? ($urandom % 3 != 0) : 1'b1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish in %0d cycles", MAX_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin : stimulus
    dword_t rd;
    logic   err;
    vaddr_t va;
    void'($urandom(25697));
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    cmd_v        = 1'b0;
    cmd_op       = e_op_load;
    cmd_vaddr    = '0;
    cmd_data     = '0;
    resp_ready   = 1'b1;
    ready_random = 1'b0;
    cycle_cnt    = 0;
    errors       = 0;
    checks       = 0;
    m_en         = 1'b0;
    m_priv       = e_priv_u;
    m_sum        = 1'b0;
    for (int i = 0; i < `MMU_TLB_ELS; i++) begin
      m_valid[i] = 1'b0;
    end
    wait (reset === 1'b0);
    @(negedge clk);
    check_value("resp_v_o", dword_t'(resp_v), 32'h0);
    check_value("cmd_ready_o", dword_t'(cmd_ready), 32'h1);
    apb_xfer(1'b0, `MMU_REG_CTRL, '0, rd, err);
    check_value("prdata_o", rd, 32'h0);

    // Bypass fills every word, then stores and reloads at random addresses
    for (int i = 0; i < `MMU_RAM_WORDS; i++) begin
      issue_cmd(e_op_store, make_vaddr(vtag_t'(i >> 4), 4'(i)),
                {8'(i) ^ 8'h5a, ~8'(i), 8'(i), 8'(i) + 8'h11});
    end
    for (int i = 0; i < 24; i++) begin
      va = make_vaddr({8'($urandom), 2'b00, 4'($urandom)}, 4'($urandom));
      issue_cmd(e_op_store, va, $urandom);
      issue_cmd(e_op_load, va, '0);
    end
    wait_drain();

    // Two translated pages and a register readback
    write_ctrl(1'b1, e_priv_m, 1'b0);
    install_entry(0, 14'h0123, 6'h03, 3'b011);
    install_entry(1, 14'h2a5c, 6'h0c, 3'b011);
    for (int i = 0; i < 16; i++) begin
      issue_cmd((i < 8) ? e_op_store : e_op_load,
                make_vaddr((i % 2) ? 14'h2a5c : 14'h0123, 4'($urandom)), $urandom);
    end
    wait_drain();
    apb_xfer(1'b0, `MMU_REG_CTRL, '0, rd, err);
    check_value("prdata_o", rd, dword_t'({m_sum, m_priv, m_en}));
    apb_xfer(1'b0, `MMU_REG_TLB_VTAG, '0, rd, err);
    check_value("prdata_o", rd, 32'h2a5c);
    apb_xfer(1'b0, `MMU_REG_TLB_ENTRY, '0, rd, err);
    check_value("prdata_o", rd, dword_t'({3'b011, 6'h0c}));

    // Misses, flush and undefined offsets
    issue_cmd(e_op_load, make_vaddr(14'h0777, 4'h4), '0);
    issue_cmd(e_op_store, make_vaddr(14'h0777, 4'h5), 32'hdead_beef);
    wait_drain();
    flush_tlb();
    issue_cmd(e_op_load, make_vaddr(14'h0123, 4'h1), '0);
    wait_drain();
    apb_xfer(1'b1, 8'h14, 32'hffff_ffff, rd, err);
    check_value("pslverr_o", dword_t'(err), 32'h1);
    apb_xfer(1'b0, 8'h40, '0, rd, err);
    check_value("pslverr_o", dword_t'(err), 32'h1);
    apb_xfer(1'b0, `MMU_REG_TLB_WRITE, '0, rd, err);
    check_value("pslverr_o", dword_t'(err), 32'h0);
    check_value("prdata_o", rd, 32'h0);

    // Page faults across S without SUM, S with SUM and U
    install_entry(0, 14'h0100, 6'h05, 3'b111);
    install_entry(1, 14'h0101, 6'h06, 3'b011);
    install_entry(2, 14'h0102, 6'h07, 3'b101);
    install_entry(3, 14'h0103, 6'h08, 3'b110);
    for (int m = 0; m < 3; m++) begin
      write_ctrl(1'b1, (m == 2) ? e_priv_u : e_priv_s, m == 1);
      for (int p = 0; p < 4; p++) begin
        issue_cmd(e_op_store, make_vaddr(vtag_t'(14'h0100 + p), 4'(m + 2)), $urandom);
        issue_cmd(e_op_load, make_vaddr(vtag_t'(14'h0100 + p), 4'(m + 2)), '0);
      end
      wait_drain();
    end

    // Remote domains in translated and bypass modes
    write_ctrl(1'b1, e_priv_m, 1'b0);
    install_entry(0, 14'h0200, 6'h25, 3'b111);
    install_entry(1, 14'h0201, 6'h31, 3'b111);
    for (int p = 0; p < 2; p++) begin
      issue_cmd(e_op_store, make_vaddr(vtag_t'(14'h0200 + p), 4'h7), $urandom);
      issue_cmd(e_op_load, make_vaddr(vtag_t'(14'h0200 + p), 4'h7), '0);
    end
    wait_drain();
    write_ctrl(1'b0, e_priv_m, 1'b0);
    issue_cmd(e_op_load, make_vaddr(14'h0015, 4'h7), '0);
    issue_cmd(e_op_load, make_vaddr(14'h0005, 4'h7), '0);
    wait_drain();

    // Back-to-back traffic with ready gaps and then with ready held high
    write_ctrl(1'b1, e_priv_m, 1'b0);
    for (int s = 0; s < `MMU_TLB_ELS; s++) begin
      install_entry(tlb_idx_t'(s), vtag_t'(14'h0300 + s), ptag_t'(s * 3), 3'b011);
    end
    for (int pass = 0; pass < 2; pass++) begin
      ready_random = (pass == 0);
      for (int i = 0; i < 60; i++) begin
        issue_cmd(($urandom % 2) ? e_op_store : e_op_load,
                  make_vaddr(vtag_t'(14'h0300 + $urandom % 5), 4'($urandom)), $urandom);
      end
      wait_drain();
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
mmu_pkg.sv
mmu_cfg_regs.sv
dtlb.sv
mmu_perm_check.sv
data_ram.sv
mem_top.sv
tb_clkgen.sv
tb_mem_top.sv

//--- Bender.yml
package:
  name: mem_top

export_include_dirs:
  - .

sources:
  - mmu_pkg.sv
  - mmu_cfg_regs.sv
  - dtlb.sv
  - mmu_perm_check.sv
  - data_ram.sv
  - mem_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_mem_top.sv
